// ==== src/pcsPkg.sv ====
package pcsPkg;

   localparam int byteWidth = 8;
   localparam int groupWidth = 10;

   // a balanced code group carries as many ones as zeros.
   localparam int onesNeutral = groupWidth / 2;

   // bit 9 is a and bit 0 is j, in abcdeifghj order.
   typedef logic [groupWidth-1:0] codeGroup;

   typedef struct packed {
      logic [byteWidth-1:0] data;
      logic                 isK;
   } txByte;

   // rxIdle holds from reset until the first group has been decoded.
   typedef enum logic [1:0] {
      rxIdle,
      rxData,
      rxControl,
      rxCodeError
   } rxStatus;

   typedef struct packed {
      logic [byteWidth-1:0] data;
      logic                 isK;
      logic                 codeErr;
   } decodeResult;

   // dispErr stands apart from status, since a valid code can still arrive
   // at the wrong running disparity.
   typedef struct packed {
      logic [byteWidth-1:0] data;
      rxStatus              status;
      logic                 dispErr;
   } rxWord;

endpackage

// ==== src/encoder8b10b.sv ====
`timescale 1ns/1ns

module encoder8b10b import pcsPkg::*; (
   input  logic     SBYTECLK,
   input  logic     reset,
   input  txByte    txIn,
   output codeGroup txGroup,
   output logic     txDisparity
);

   typedef struct packed {
      logic [5:0] raw6;
      logic [3:0] raw4;
      logic       alt7;
      logic       compl6;
      logic       compl4;
   } encStage;

   logic a, b, c, d, e, f, g, h, k;
   logic aEqB, cEqD;
   logic l40, l04, l13, l31, l22;
   logic x24, x7;
   logic pos6, complOnNeg6, complOnPos6, flip6;
   logic complOnNeg4, complOnPos4, flip4;
   logic disp6;
   logic runDisp;
   logic [3:0] fixed4;
   encStage stageNext;
   encStage stageReg;

   // classify the low five bits by how many of A to D are set.
   always_comb begin
      {h, g, f, e, d, c, b, a} = txIn.data;
      k = txIn.isK;
      aEqB = (a == b);
      cEqD = (c == d);
      l40 = a & b & c & d;
      l04 = !a & !b & !c & !d;
      l13 = (!aEqB & !c & !d) | (!cEqD & !a & !b);
      l31 = (!aEqB & c & d) | (!cEqD & a & b);
      l22 = (a & b & !c & !d) | (c & d & !a & !b) | (!aEqB & !cEqD);
      x24 = e & d & !c & !b & !a;
      x7 = !e & !d & c & b & a;
   end

   // complement decisions for each sub-block, and whether it moves disparity.
   always_comb begin
      pos6 = k | (e & !l22 & !l13);
      complOnNeg6 = x24 | (!e & !l22 & !l31);
      complOnPos6 = pos6 | x7;
      flip6 = complOnNeg6 | pos6;
      complOnNeg4 = (!f & !g) | (k & (f ^ g));
      complOnPos4 = f & g;
      flip4 = (f & g & h) | (!f & !g);
      // the 3b/4b sub-block is coded at the disparity left by the 5b/6b one.
      disp6 = runDisp ^ flip6;
   end

   always_comb begin
      stageNext.raw6[5] = a;
      stageNext.raw6[4] = (b & !l40) | l04;
      stageNext.raw6[3] = l04 | c | x24;
      stageNext.raw6[2] = d & !(a & b & c);
      stageNext.raw6[1] = (e | l13) & !x24;
      stageNext.raw6[0] = (l22 & !e) | (e & l40) | (e & !d & !c & !(a & b)) |
                          (k & e & d & c & !b & !a) | (e & !d & c & !b & !a);
      stageNext.raw4 = {f, g | (!f & !g & !h), h, !h & (g ^ f)};
      // D.x.A7 avoids a run of five equal bits across the sub-block boundary.
      stageNext.alt7 = f & g & h & (k | (runDisp ? (!e & d & l31) : (e & !d & l13)));
      stageNext.compl6 = (complOnNeg6 & !runDisp) | (complOnPos6 & runDisp);
      stageNext.compl4 = (complOnNeg4 & !disp6) | (complOnPos4 & disp6);
   end

   assign fixed4 = {stageReg.raw4[3] & !stageReg.alt7,
                    stageReg.raw4[2],
                    stageReg.raw4[1],
                    stageReg.raw4[0] | stageReg.alt7};

   // runDisp already covers the byte in stage one, so txDisparity is delayed
   // by one cycle to line up with the group on txGroup.
   always_ff @(posedge SBYTECLK or posedge reset) begin
      if (reset) begin
         stageReg <= '0;
         runDisp <= 1'b0;
         txGroup <= '0;
         txDisparity <= 1'b0;
      end else begin
         stageReg <= stageNext;
         runDisp <= disp6 ^ flip4;
         txGroup <= {stageReg.raw6 ^ {6{stageReg.compl6}},
                     fixed4 ^ {4{stageReg.compl4}}};
         txDisparity <= runDisp;
      end
   end

endmodule

// ==== src/codeGroupDecoder.sv ====
`timescale 1ns/1ns

module codeGroupDecoder import pcsPkg::*; (
   input  logic        SBYTECLK,
   input  logic        reset,
   input  codeGroup    rxGroup,
   output decodeResult result
);

   logic [5:0] six;
   logic [3:0] four;
   logic [5:0] dec6;
   logic [3:0] dec4;
   logic [4:0] x;
   logic k28, a7, kx7, dataA7, badA7, badP7;
   logic [2:0] ones6;
   logic [2:0] ones4;
   logic rdPos6, rdNeg6, needPos4, needNeg4, dispBad;
   decodeResult nextResult;

   // returns {valid, EDCBA} for a data abcdei sub-block in either disparity form.
   function automatic logic [5:0] decode6(input logic [5:0] sub);
      case (sub)
         6'b100111, 6'b011000: decode6 = {1'b1, 5'd0};
         6'b011101, 6'b100010: decode6 = {1'b1, 5'd1};
         6'b101101, 6'b010010: decode6 = {1'b1, 5'd2};
         6'b110001:            decode6 = {1'b1, 5'd3};
         6'b110101, 6'b001010: decode6 = {1'b1, 5'd4};
         6'b101001:            decode6 = {1'b1, 5'd5};
         6'b011001:            decode6 = {1'b1, 5'd6};
         6'b111000, 6'b000111: decode6 = {1'b1, 5'd7};
         6'b111001, 6'b000110: decode6 = {1'b1, 5'd8};
         6'b100101:            decode6 = {1'b1, 5'd9};
         6'b010101:            decode6 = {1'b1, 5'd10};
         6'b110100:            decode6 = {1'b1, 5'd11};
         6'b001101:            decode6 = {1'b1, 5'd12};
         6'b101100:            decode6 = {1'b1, 5'd13};
         6'b011100:            decode6 = {1'b1, 5'd14};
         6'b010111, 6'b101000: decode6 = {1'b1, 5'd15};
         6'b011011, 6'b100100: decode6 = {1'b1, 5'd16};
         6'b100011:            decode6 = {1'b1, 5'd17};
         6'b010011:            decode6 = {1'b1, 5'd18};
         6'b110010:            decode6 = {1'b1, 5'd19};
         6'b001011:            decode6 = {1'b1, 5'd20};
         6'b101010:            decode6 = {1'b1, 5'd21};
         6'b011010:            decode6 = {1'b1, 5'd22};
         6'b111010, 6'b000101: decode6 = {1'b1, 5'd23};
         6'b110011, 6'b001100: decode6 = {1'b1, 5'd24};
         6'b100110:            decode6 = {1'b1, 5'd25};
         6'b010110:            decode6 = {1'b1, 5'd26};
         6'b110110, 6'b001001: decode6 = {1'b1, 5'd27};
         6'b001110:            decode6 = {1'b1, 5'd28};
         6'b101110, 6'b010001: decode6 = {1'b1, 5'd29};
         6'b011110, 6'b100001: decode6 = {1'b1, 5'd30};
         6'b101011, 6'b010100: decode6 = {1'b1, 5'd31};
         default:              decode6 = 6'b0;
      endcase
   endfunction

   // only all zeros and all ones are missing from the fghj table.
   function automatic logic [3:0] decode4(input logic [3:0] sub);
      case (sub)
         4'b1011, 4'b0100:                   decode4 = {1'b1, 3'd0};
         4'b1001:                            decode4 = {1'b1, 3'd1};
         4'b0101:                            decode4 = {1'b1, 3'd2};
         4'b1100, 4'b0011:                   decode4 = {1'b1, 3'd3};
         4'b1101, 4'b0010:                   decode4 = {1'b1, 3'd4};
         4'b1010:                            decode4 = {1'b1, 3'd5};
         4'b0110:                            decode4 = {1'b1, 3'd6};
         4'b1110, 4'b0001, 4'b0111, 4'b1000: decode4 = {1'b1, 3'd7};
         default:                            decode4 = 4'b0;
      endcase
   endfunction

   always_comb begin
      six = rxGroup[9:4];
      four = rxGroup[3:0];
      k28 = (six == 6'b001111) || (six == 6'b110000);
      dec6 = decode6(six);
      // K28 sent at positive disparity is the inverse of its negative form.
      dec4 = decode4((six == 6'b110000) ? ~four : four);
      x = k28 ? 5'd28 : dec6[4:0];
      a7 = (four == 4'b0111) || (four == 4'b1000);
      kx7 = a7 && !k28 && dec6[5] && (x inside {5'd23, 5'd27, 5'd29, 5'd30});
      dataA7 = ((four == 4'b0111) && (x inside {5'd17, 5'd18, 5'd20})) ||
               ((four == 4'b1000) && (x inside {5'd11, 5'd13, 5'd14}));
      badA7 = a7 && !k28 && !kx7 && !dataA7;
      badP7 = ((four == 4'b1110) && (six[1:0] == 2'b11)) ||
              ((four == 4'b0001) && (six[1:0] == 2'b00));
      ones6 = 3'($countones(six));
      ones4 = 3'($countones(four));
      // disparity left by the 6b sub-block must suit the form of the 4b one.
      rdPos6 = (ones6 == 3'd4) || (six == 6'b000111);
      rdNeg6 = (ones6 == 3'd2) || (six == 6'b111000);
      needNeg4 = (ones4 == 3'd3) || (four == 4'b1100);
      needPos4 = (ones4 == 3'd1) || (four == 4'b0011);
      dispBad = (rdPos6 && needNeg4) || (rdNeg6 && needPos4);
      nextResult.data = {dec4[2:0], x};
      nextResult.isK = k28 || kx7;
      nextResult.codeErr = !(dec6[5] || k28) || !dec4[3] || badA7 || badP7 || dispBad;
   end

   always_ff @(posedge SBYTECLK or posedge reset) begin
      if (reset) begin
         result <= '0;
      end else begin
         result <= nextResult;
      end
   end

endmodule

// ==== src/disparityChecker.sv ====
`timescale 1ns/1ns

module disparityChecker import pcsPkg::*; (
   input  logic     SBYTECLK,
   input  logic     reset,
   input  codeGroup rxGroup,
   output logic     dispErr
);

   logic [3:0] ones;
   logic posGroup;
   logic negGroup;
   logic runDisp;

   always_comb begin
      ones = 4'($countones(rxGroup));
      posGroup = (ones == 4'(onesNeutral + 1));
      negGroup = (ones == 4'(onesNeutral - 1));
   end

   // runDisp high means positive.
   // a group with any other count is left to the decoder.
   always_ff @(posedge SBYTECLK or posedge reset) begin
      if (reset) begin
         runDisp <= 1'b0;
         dispErr <= 1'b0;
      end else begin
         dispErr <= (posGroup && runDisp) || (negGroup && !runDisp);
         // an unbalanced group moves disparity even when it arrives in error.
         if (posGroup || negGroup) begin
            runDisp <= !runDisp;
         end
      end
   end

endmodule

// ==== src/rxMerge.sv ====
`timescale 1ns/1ns

module rxMerge import pcsPkg::*; #(
   parameter int errCountWidth = 8
) (
   input  logic                     SBYTECLK,
   input  logic                     reset,
   input  decodeResult              result,
   input  logic                     dispErr,
   output rxWord                    rxOut,
   output logic [errCountWidth-1:0] errCount
);

   localparam logic [errCountWidth-1:0] errMax = '1;

   logic primed;
   logic wordErr;
   rxWord nextWord;

   always_comb begin
      nextWord.dispErr = dispErr;
      if (result.codeErr) begin
         nextWord.data = '0;
         nextWord.status = rxCodeError;
      end else begin
         nextWord.data = result.data;
         nextWord.status = result.isK ? rxControl : rxData;
      end
      wordErr = result.codeErr || dispErr;
   end

   // for the first cycle out of reset the receive blocks still hold their
   // reset values, so the word stays idle until primed is set.
   always_ff @(posedge SBYTECLK or posedge reset) begin
      if (reset) begin
         primed <= 1'b0;
         rxOut.data <= '0;
         rxOut.status <= rxIdle;
         rxOut.dispErr <= 1'b0;
         errCount <= '0;
      end else begin
         primed <= 1'b1;
         if (primed) begin
            rxOut <= nextWord;
            if (wordErr && (errCount != errMax)) begin
               errCount <= errCount + 1'b1;
            end
         end
      end
   end

endmodule

// ==== src/pcsLoopbackTop.sv ====
`timescale 1ns/1ns

module pcsLoopbackTop import pcsPkg::*; #(
   parameter int errCountWidth = 8
) (
   input  logic                     SBYTECLK,
   input  logic                     reset,
   input  txByte                    txIn,
   output codeGroup                 txGroup,
   output logic                     txDisparity,
   input  codeGroup                 rxGroup,
   output rxWord                    rxOut,
   output logic [errCountWidth-1:0] errCount
);

   decodeResult decoded;
   logic groupDispErr;

   encoder8b10b encoder0 (
      .SBYTECLK    (SBYTECLK),
      .reset       (reset),
      .txIn        (txIn),
      .txGroup     (txGroup),
      .txDisparity (txDisparity)
   );

   // decoder and checker look at the same group in the same cycle.
   codeGroupDecoder decoder0 (
      .SBYTECLK (SBYTECLK),
      .reset    (reset),
      .rxGroup  (rxGroup),
      .result   (decoded)
   );

   disparityChecker checker0 (
      .SBYTECLK (SBYTECLK),
      .reset    (reset),
      .rxGroup  (rxGroup),
      .dispErr  (groupDispErr)
   );

   rxMerge #(
      .errCountWidth (errCountWidth)
   ) merge0 (
      .SBYTECLK (SBYTECLK),
      .reset    (reset),
      .result   (decoded),
      .dispErr  (groupDispErr),
      .rxOut    (rxOut),
      .errCount (errCount)
   );

endmodule

// ==== dv/pcs_assertions.sv ====
`timescale 1ns/1ns

module pcsAssertions import pcsPkg::*; (
   input logic     SBYTECLK,
   input logic     reset,
   input codeGroup txGroup,
   input logic     txDisparity
);

   logic [1:0] settle;
   logic [3:0] ones;

   assign ones = 4'($countones(txGroup));

   // the encoder pipeline still shows zeros for two edges after reset is released.
   always_ff @(posedge SBYTECLK or posedge reset) begin
      if (reset) begin
         settle <= 2'd0;
      end else if (settle != 2'd2) begin
         settle <= settle + 2'd1;
      end
   end

   groupOnesLegal: assert property (@(posedge SBYTECLK) disable iff (reset)
      (settle == 2'd2) |-> (ones >= 4'd4 && ones <= 4'd6))
      else $error("txGroup %h carries %0d ones", txGroup, ones);

   // txDisparity is the disparity after its group, so the past value is the one before.
   sixOnesAfterNegative: assert property (@(posedge SBYTECLK) disable iff (reset)
      (settle == 2'd2 && ones == 4'd6) |-> !$past(txDisparity))
      else $error("txGroup %h with six ones follows positive disparity", txGroup);

   zeroInReset: assert property (@(posedge SBYTECLK) reset |-> (txGroup == '0))
      else $error("txGroup %h is not zero during reset", txGroup);

endmodule

// ==== dv/pcsTb.sv ====
`timescale 1ns/1ns

module pcsTb import pcsPkg::*; ();

   localparam int clkPeriod = 10;
   localparam int errWidth = 3;
   localparam int errLimit = (1 << errWidth) - 1;
   // D21.5 is balanced in both forms, so it decodes cleanly at either disparity.
   localparam codeGroup fillGroup = 10'b1010101010;
   localparam logic [7:0] fillByte = 8'hB5;
   localparam logic [7:0] kCodes [12] = '{8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC,
                                          8'hDC, 8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE};

   typedef enum logic [1:0] {
      modeClean,
      modeSubst,
      modeReplay
   } loopMode;

   typedef struct packed {
      logic [7:0] data;
      logic       isK;
      loopMode    mode;
      rxStatus    expStatus;
   } stimEntry;

   logic SBYTECLK = 1'b0;
   logic reset;
   txByte txIn;
   codeGroup txGroup;
   logic txDisparity;
   codeGroup rxGroup;
   rxWord rxOut;
   logic [errWidth-1:0] errCount;

   stimEntry stimTable[$];
   int failsOf[int];
   int checkErrors = 0;
   int testsRun = 0;
   int testsFailed = 0;
   logic tableReady = 1'b0;
   logic [31:0] rngState = 32'd66;

   pcsLoopbackTop #(
      .errCountWidth (errWidth)
   ) dut0 (
      .SBYTECLK    (SBYTECLK),
      .reset       (reset),
      .txIn        (txIn),
      .txGroup     (txGroup),
      .txDisparity (txDisparity),
      .rxGroup     (rxGroup),
      .rxOut       (rxOut),
      .errCount    (errCount)
   );

   bind encoder8b10b pcsAssertions assertions0 (
      .SBYTECLK    (SBYTECLK),
      .reset       (reset),
      .txGroup     (txGroup),
      .txDisparity (txDisparity)
   );

   always #(clkPeriod / 2) SBYTECLK = !SBYTECLK;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int onesOf(input codeGroup grp);
      int n;
      n = 0;
      for (int i = 0; i < 10; i++) begin
         n += int'(grp[i]);
      end
      return n;
   endfunction

   task automatic noteFailure(input int idx);
      checkErrors++;
      failsOf[idx]++;
   endtask

   task automatic compareStatus(input int idx, input string name, input rxStatus got,
                                input rxStatus want);
      if (got !== want) begin
         $display("mismatch test %0d %s: got %h expected %h", idx, name, got, want);
         noteFailure(idx);
      end
   endtask

   task automatic compareByte(input int idx, input string name, input logic [7:0] got,
                              input logic [7:0] want);
      if (got !== want) begin
         $display("mismatch test %0d %s: got %h expected %h", idx, name, got, want);
         noteFailure(idx);
      end
   endtask

   task automatic compareFlag(input int idx, input string name, input logic got,
                              input logic want);
      if (got !== want) begin
         $display("mismatch test %0d %s: got %h expected %h", idx, name, got, want);
         noteFailure(idx);
      end
   endtask

   task automatic compareCount(input int idx, input string name,
                               input logic [errWidth-1:0] got,
                               input logic [errWidth-1:0] want);
      if (got !== want) begin
         $display("mismatch test %0d %s: got %h expected %h", idx, name, got, want);
         noteFailure(idx);
      end
   endtask

   // an unbalanced group must move disparity away from its current sign.
   task automatic compareOnes(input int idx, input codeGroup grp, input logic rdPos);
      int ones;
      int want;
      ones = onesOf(grp);
      want = rdPos ? 4 : 6;
      if (ones != 5 && ones != want) begin
         $display("mismatch test %0d txGroup %h ones: got %h expected 5 or %h",
                  idx, grp, ones, want);
         noteFailure(idx);
      end
   endtask

   task automatic reportTest(input int idx, input string label);
      testsRun++;
      if (failsOf[idx] != 0) begin
         testsFailed++;
         $display("test %0d %s: FAIL", idx, label);
      end else begin
         $display("test %0d %s: ok", idx, label);
      end
   endtask

   task automatic pushStimulus(input logic [7:0] data, input logic isK, input loopMode mode,
                               input rxStatus expStatus);
      stimEntry e;
      e.data = data;
      e.isK = isK;
      e.mode = mode;
      e.expStatus = expStatus;
      failsOf[stimTable.size()] = 0;
      stimTable.push_back(e);
   endtask

   task automatic buildTable();
      for (int i = 0; i < 256; i++) begin
         pushStimulus(8'(i), 1'b0, modeClean, rxData);
      end
      for (int i = 0; i < 12; i++) begin
         pushStimulus(kCodes[i], 1'b1, modeClean, rxControl);
      end
      // K28.5 is always unbalanced, so replaying it over the next K28.5 repeats
      // a disparity. The substituted D21.5 is balanced and leaves both sides in step.
      for (int i = 0; i < 5; i++) begin
         pushStimulus(8'hBC, 1'b1, modeClean, rxControl);
         pushStimulus(8'hBC, 1'b1, modeReplay, rxControl);
         pushStimulus(fillByte, 1'b0, modeSubst, rxCodeError);
         rngState = xorshift32(rngState);
         pushStimulus(rngState[7:0], 1'b0, modeClean, rxData);
         rngState = xorshift32(rngState);
         pushStimulus(rngState[7:0], 1'b0, modeClean, rxData);
      end
   endtask

   initial begin
      int numEntries;
      int expErrs;
      int ones;
      int j;
      logic txRdPos;
      codeGroup lastUnbal;
      stimEntry e;
      txIn.data = fillByte;
      txIn.isK = 1'b0;
      rxGroup = fillGroup;
      reset = 1'b1;
      expErrs = 0;
      txRdPos = 1'b0;
      lastUnbal = fillGroup;
      failsOf[-1] = 0;
      buildTable();
      numEntries = stimTable.size();
      tableReady = 1'b1;
      repeat (2) @(posedge SBYTECLK);
      #1;
      reset = 1'b0;
      // step c runs 1 ns after the c-th edge from release, when the group of
      // entry c-2 is on txGroup and the word of entry c-4 is on rxOut.
      for (int c = 0; c < numEntries + 4; c++) begin
         if (c > 0) begin
            @(posedge SBYTECLK);
            #1;
         end
         if (c < 2) begin
            compareStatus(-1, "rxOut.status", rxOut.status, rxIdle);
            compareCount(-1, "errCount", errCount, '0);
            compareFlag(-1, "txDisparity", txDisparity, 1'b0);
            if (c == 1) begin
               reportTest(-1, "reset state");
            end
         end
         if (c >= 4) begin
            j = c - 4;
            e = stimTable[j];
            if (e.mode != modeClean && expErrs < errLimit) begin
               expErrs++;
            end
            compareByte(j, "rxOut.data", rxOut.data, (e.mode == modeSubst) ? 8'h00 : e.data);
            compareStatus(j, "rxOut.status", rxOut.status, e.expStatus);
            compareFlag(j, "rxOut.dispErr", rxOut.dispErr, e.mode == modeReplay);
            compareCount(j, "errCount", errCount, errWidth'(expErrs));
            reportTest(j, $sformatf("%s byte %h isK %0d", e.mode.name(), e.data, e.isK));
         end
         if (c >= 2 && c - 2 < numEntries) begin
            j = c - 2;
            e = stimTable[j];
            compareOnes(j, txGroup, txRdPos);
            ones = onesOf(txGroup);
            if (ones == 4 || ones == 6) begin
               txRdPos = !txRdPos;
            end
            compareFlag(j, "txDisparity", txDisparity, txRdPos);
            case (e.mode)
               modeSubst:  rxGroup = '0;
               modeReplay: rxGroup = lastUnbal;
               default:    rxGroup = txGroup;
            endcase
            ones = onesOf(rxGroup);
            if (ones == 4 || ones == 6) begin
               lastUnbal = rxGroup;
            end
         end
         if (c < numEntries) begin
            txIn.data = stimTable[c].data;
            txIn.isK = stimTable[c].isK;
         end else begin
            txIn.data = fillByte;
            txIn.isK = 1'b0;
         end
      end
      $display("summary: %0d run, %0d passed, %0d failed, %0d check errors",
               testsRun, testsRun - testsFailed, testsFailed, checkErrors);
      if (checkErrors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin
      wait (tableReady);
      #((stimTable.size() + 20) * clkPeriod);
      $display("timeout: the run did not end within %0d cycles", stimTable.size() + 20);
      $display("tests failed");
      $finish;
   end

endmodule

// ==== src.f ====
src/pcsPkg.sv
src/encoder8b10b.sv
src/codeGroupDecoder.sv
src/disparityChecker.sv
src/rxMerge.sv
src/pcsLoopbackTop.sv
dv/pcs_assertions.sv
dv/pcsTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pcsTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG) || \
	   ! grep -q "all tests passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi; \
	echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
